//--- bullet_unit.sv
// One tank's bullet. A rising shoot edge in IDLE launches it from the
// muzzle; it then flies four pixels per tick along the heading it was
// fired with, and ends on the first hard pixel it covers.

`include "tank_settings.svh"

module bullet_unit (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 shoot_i,
    input  logic                 move_tick_i,
    input  tank_pkg::tank_pose_t pose_i,
    raster_if.probe              raster,
    output logic                 bullet_pixel_o
);

    import tank_pkg::*;

    localparam coord_t STEP        = coord_t'(`BULLET_STEP);
    localparam coord_t SIZE        = coord_t'(`BULLET_SIZE);
    localparam coord_t MUZZLE_SIDE = coord_t'(`MUZZLE_SIDE);
    localparam coord_t MUZZLE_FAR  = coord_t'(`MUZZLE_FAR);
    localparam coord_t MUZZLE_NEAR = coord_t'(`MUZZLE_NEAR);

    bullet_state_t state_q;
    logic          shoot_q;
    logic          fire;
    coord_t        muzzle_x;
    coord_t        muzzle_y;
    coord_t        bullet_x;
    coord_t        bullet_y;
    dir_t          bullet_dir;
    coord_t        dx;
    coord_t        dy;

    //////////////////////////////////////////////////
    // shoot edge and state machine
    //////////////////////////////////////////////////

    assign fire = shoot_i && !shoot_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            shoot_q <= 1'b0;
            state_q <= IDLE;
        end else begin
            shoot_q <= shoot_i;
            case (state_q)
                IDLE: begin
                    if (fire) state_q <= FLYING;
                end
                FLYING: begin
                    if (bullet_pixel_o && raster.hard) state_q <= SPENT;
                end
                SPENT:   state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // muzzle and flight
    //////////////////////////////////////////////////

    always_comb begin
        case (pose_i.heading)
            DIR_UP: begin
                muzzle_x = pose_i.x + MUZZLE_SIDE;
                muzzle_y = pose_i.y - MUZZLE_NEAR;
            end
            DIR_RIGHT: begin
                muzzle_x = pose_i.x + MUZZLE_FAR;
                muzzle_y = pose_i.y + MUZZLE_SIDE;
            end
            DIR_LEFT: begin
                muzzle_x = pose_i.x - MUZZLE_NEAR;
                muzzle_y = pose_i.y + MUZZLE_SIDE;
            end
            default: begin // down
                muzzle_x = pose_i.x + MUZZLE_SIDE;
                muzzle_y = pose_i.y + MUZZLE_FAR;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            IDLE: begin
                bullet_x   <= muzzle_x; // track the tank until fired
                bullet_y   <= muzzle_y;
                bullet_dir <= pose_i.heading;
            end
            FLYING: begin
                if (move_tick_i) begin
                    case (bullet_dir)
                        DIR_DOWN:  bullet_y <= bullet_y + STEP;
                        DIR_UP:    bullet_y <= bullet_y - STEP;
                        DIR_RIGHT: bullet_x <= bullet_x + STEP;
                        DIR_LEFT:  bullet_x <= bullet_x - STEP;
                        default:   ;
                    endcase
                end
            end
            default: ; // hold while spent
        endcase
    end

    assign dx = raster.hpos - bullet_x;
    assign dy = raster.vpos - bullet_y;

    assign bullet_pixel_o = (state_q == FLYING) && (dx <= SIZE) && (dy <= SIZE);

    // a hard hit blanks the bullet through SPENT and the following IDLE
    a_hit_blanks: assert property (
        @(posedge clk_i) disable iff (reset_i)
        bullet_pixel_o && raster.hard |=> !bullet_pixel_o ##1 !bullet_pixel_o
    );

endmodule

//--- hull_probe.sv
// Hull pixel test and wall contact flags for one tank.
// The hull pixel is combinational on the raster position; the four
// blocked flags are sticky and feed tank_motion, indexed like dir_t.

`include "tank_settings.svh"

module hull_probe (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  tank_pkg::tank_pose_t pose_i,
    input  tank_pkg::dir_t       move_i,
    raster_if.probe              raster,
    output logic                 hull_pixel_o,
    output logic [3:0]           blocked_o
);

    import tank_pkg::*;

    localparam coord_t HULL_MIN  = coord_t'(`TANK_HULL_MIN);
    localparam coord_t HULL_MAX  = coord_t'(`TANK_HULL_MAX);
    localparam coord_t LINE_NEAR = coord_t'(`TANK_HULL_MIN - 1); // top or left line
    localparam coord_t LINE_FAR  = coord_t'(`TANK_HULL_MAX + 1); // bottom or right line
    localparam coord_t SPAN_LO   = coord_t'(`TANK_HULL_MIN + 1);
    localparam coord_t SPAN_HI   = coord_t'(`TANK_HULL_MAX - 1);

    coord_t     dx;
    coord_t     dy;
    logic       span_x;
    logic       span_y;
    logic [3:0] contact;
    logic [3:0] hits;
    logic [3:0] keep_mask;

    assign dx = raster.hpos - pose_i.x; // wraps modulo 1024
    assign dy = raster.vpos - pose_i.y;

    assign hull_pixel_o = (dx >= HULL_MIN) && (dx <= HULL_MAX) &&
                          (dy >= HULL_MIN) && (dy <= HULL_MAX);

    //////////////////////////////////////////////////
    // edge contact lines
    //////////////////////////////////////////////////

    assign span_x = (dx >= SPAN_LO) && (dx <= SPAN_HI);
    assign span_y = (dy >= SPAN_LO) && (dy <= SPAN_HI);

    assign contact[0] = (dy == LINE_FAR)  && span_x; // bottom
    assign contact[1] = (dy == LINE_NEAR) && span_x; // top
    assign contact[2] = (dx == LINE_FAR)  && span_y; // right
    assign contact[3] = (dx == LINE_NEAR) && span_y; // left

    assign hits = contact & {4{raster.solid}};

    // a clean one-hot turn keeps only its own flag
    always_comb begin
        case (move_i)
            DIR_DOWN, DIR_UP, DIR_RIGHT, DIR_LEFT: keep_mask = move_i;
            default:                               keep_mask = 4'b1111;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            blocked_o <= 4'b0000;
        end else begin
            blocked_o <= (blocked_o & keep_mask) | hits; // set wins
        end
    end

    // a flag is only raised by a solid pixel
    a_set_needs_solid: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !raster.solid |=> (blocked_o & ~$past(blocked_o)) == 4'b0000
    );

endmodule

//--- raster_if.sv
// Current raster pixel and its map properties, fanned out to the hull
// probes and bullet units. Driven from plain ports in the top level.

`include "tank_settings.svh"

interface raster_if;

    import tank_pkg::*;

    coord_t hpos;  // raster column
    coord_t vpos;  // raster row
    logic   solid; // tanks cannot pass
    logic   hard;  // bullets stop here

    modport probe (
        input hpos,
        input vpos,
        input solid,
        input hard
    );

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the tank arena testbench with Verilator, runs it and scans the log.
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_tank_arena -f tank_arena.f

./obj_dir/Vtb_tank_arena 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failures"

//--- tank_arena.f
+incdir+.
tank_pkg.sv
raster_if.sv
hull_probe.sv
tank_motion.sv
bullet_unit.sv
tank_arena_top.sv
tb_tank_arena.sv

//--- tank_arena_top.sv
// Game logic of the two-tank arena. Per raster pixel it reports each
// hull, either bullet, and a bullet landing on a destroyable brick.
// Drive hpos/vpos and the map flags for the same pixel every clock.

`include "tank_settings.svh"

module tank_arena_top (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             move_tick_i,
    input  tank_pkg::dir_t   player_1_move_i,
    input  tank_pkg::dir_t   player_2_move_i,
    input  logic             player_1_shoot_i,
    input  logic             player_2_shoot_i,
    input  tank_pkg::coord_t hpos_i,
    input  tank_pkg::coord_t vpos_i,
    input  logic             cannot_walk_through_i,
    input  logic             hard_block_i,
    input  logic             destroyable_block_i,
    output logic             player_1_pixel_o,
    output logic             player_2_pixel_o,
    output logic             bullet_pixel_o,
    output logic             bullet_collide_o
);

    import tank_pkg::*;

    tank_pose_t pose_p1;
    tank_pose_t pose_p2;
    logic [3:0] blocked_p1;
    logic [3:0] blocked_p2;
    logic       bullet_p1;
    logic       bullet_p2;

    raster_if raster ();

    assign raster.hpos  = hpos_i;
    assign raster.vpos  = vpos_i;
    assign raster.solid = cannot_walk_through_i;
    assign raster.hard  = hard_block_i;

    //////////////////////////////////////////////////
    // player 1, starts at the top heading down
    //////////////////////////////////////////////////

    tank_motion #(
        .X_INIT       (coord_t'(`TANK_P1_X_INIT)),
        .Y_INIT       (coord_t'(`TANK_P1_Y_INIT)),
        .HEADING_INIT (DIR_DOWN)
    ) motion_p1 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .move_i      (player_1_move_i),
        .move_tick_i (move_tick_i),
        .blocked_i   (blocked_p1),
        .pose_o      (pose_p1)
    );

    hull_probe probe_p1 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .pose_i       (pose_p1),
        .move_i       (player_1_move_i),
        .raster       (raster.probe),
        .hull_pixel_o (player_1_pixel_o),
        .blocked_o    (blocked_p1)
    );

    bullet_unit bullet_u1 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .shoot_i        (player_1_shoot_i),
        .move_tick_i    (move_tick_i),
        .pose_i         (pose_p1),
        .raster         (raster.probe),
        .bullet_pixel_o (bullet_p1)
    );

    //////////////////////////////////////////////////
    // player 2, starts at the bottom heading up
    //////////////////////////////////////////////////

    tank_motion #(
        .X_INIT       (coord_t'(`TANK_P2_X_INIT)),
        .Y_INIT       (coord_t'(`TANK_P2_Y_INIT)),
        .HEADING_INIT (DIR_UP)
    ) motion_p2 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .move_i      (player_2_move_i),
        .move_tick_i (move_tick_i),
        .blocked_i   (blocked_p2),
        .pose_o      (pose_p2)
    );

    hull_probe probe_p2 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .pose_i       (pose_p2),
        .move_i       (player_2_move_i),
        .raster       (raster.probe),
        .hull_pixel_o (player_2_pixel_o),
        .blocked_o    (blocked_p2)
    );

    bullet_unit bullet_u2 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .shoot_i        (player_2_shoot_i),
        .move_tick_i    (move_tick_i),
        .pose_i         (pose_p2),
        .raster         (raster.probe),
        .bullet_pixel_o (bullet_p2)
    );

    assign bullet_pixel_o   = bullet_p1 | bullet_p2;
    assign bullet_collide_o = destroyable_block_i && bullet_pixel_o; // brick hit

endmodule

//--- tank_motion.sv
// Pose register of one tank. On a movement tick a one-hot command whose
// blocked flag is clear steps the hull one pixel and takes the heading.

`include "tank_settings.svh"

module tank_motion #(
    parameter tank_pkg::coord_t X_INIT       = tank_pkg::coord_t'(`TANK_P1_X_INIT),
    parameter tank_pkg::coord_t Y_INIT       = tank_pkg::coord_t'(`TANK_P1_Y_INIT),
    parameter tank_pkg::dir_t   HEADING_INIT = tank_pkg::DIR_DOWN
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  tank_pkg::dir_t       move_i,
    input  logic                 move_tick_i,
    input  logic [3:0]           blocked_i,
    output tank_pkg::tank_pose_t pose_o
);

    import tank_pkg::*;

    localparam coord_t STEP = coord_t'(`TANK_STEP);

    tank_pose_t next_pose;
    logic       valid_move;
    logic       can_step;

    always_comb begin
        next_pose  = pose_o;
        valid_move = 1'b1;
        case (move_i)
            DIR_DOWN:  next_pose.y = pose_o.y + STEP;
            DIR_UP:    next_pose.y = pose_o.y - STEP;
            DIR_RIGHT: next_pose.x = pose_o.x + STEP;
            DIR_LEFT:  next_pose.x = pose_o.x - STEP;
            default:   valid_move = 1'b0; // idle or several keys
        endcase
        next_pose.heading = valid_move ? move_i : pose_o.heading;
    end

    assign can_step = valid_move && ((blocked_i & move_i) == 4'b0000);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pose_o.x       <= X_INIT;
            pose_o.y       <= Y_INIT;
            pose_o.heading <= HEADING_INIT;
        end else if (move_tick_i && can_step) begin
            pose_o <= next_pose;
        end
    end

    // the hull only moves on tick cycles
    a_pose_on_tick: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !move_tick_i |=> $stable(pose_o)
    );

endmodule

//--- tank_pkg.sv
// Types for the tank arena: headings, raster coordinates, tank pose
// and the bullet state. Modules import it inside their bodies.

`include "tank_settings.svh"

package tank_pkg;

    //////////////////////////////////////////////////
    // coordinates and headings
    //////////////////////////////////////////////////

    typedef logic [`TANK_COORD_BITS-1:0] coord_t;

    // one-hot heading; other codes may arrive on the move inputs
    typedef logic [3:0] dir_t;

    localparam dir_t DIR_DOWN  = 4'b0001;
    localparam dir_t DIR_UP    = 4'b0010;
    localparam dir_t DIR_RIGHT = 4'b0100;
    localparam dir_t DIR_LEFT  = 4'b1000;

    //////////////////////////////////////////////////
    // tank and bullet state
    //////////////////////////////////////////////////

    typedef struct packed {
        coord_t x;       // hull corner, left
        coord_t y;       // hull corner, top
        dir_t   heading; // last direction moved
    } tank_pose_t;

    typedef enum logic [1:0] {
        IDLE   = 2'd0, // riding on the muzzle
        FLYING = 2'd1,
        SPENT  = 2'd2  // one cycle after a hard hit
    } bullet_state_t;

endpackage

//--- tank_settings.svh
// Arena constants shared by the package, the RTL and the testbench.
// Include this file wherever a macro below is needed; the guard makes
// repeated includes harmless.

`ifndef TANK_SETTINGS_SVH
`define TANK_SETTINGS_SVH

//////////////////////////////////////////////////
// raster geometry
//////////////////////////////////////////////////

`define TANK_COORD_BITS 10 // 1024 wide, wraps modulo

//////////////////////////////////////////////////
// start positions, upper-left hull corner
//////////////////////////////////////////////////

`define TANK_P1_X_INIT 224
`define TANK_P1_Y_INIT 32
`define TANK_P2_X_INIT 224
`define TANK_P2_Y_INIT 416

//////////////////////////////////////////////////
// hull and bullet geometry
//////////////////////////////////////////////////

`define TANK_HULL_MIN 3  // first hull offset
`define TANK_HULL_MAX 28 // last hull offset

`define TANK_STEP   1 // pixels per tick
`define BULLET_STEP 4 // pixels per tick
`define BULLET_SIZE 4 // offsets 0..4 are lit

// muzzle placement relative to the hull corner
`define MUZZLE_SIDE 14 // centred across the barrel
`define MUZZLE_FAR  32 // just past the hull, down or right
`define MUZZLE_NEAR 4  // just before the hull, up or left

`endif

//--- tb_tank_arena.sv
// Self-checking testbench for the tank arena top level.
// A table of moves, shots and raster probes is applied row by row. Each
// row's expected flags are checked on the DUT and against a cycle model.

`include "tank_settings.svh"

module tb_tank_arena;

    timeunit 1ns;
    timeprecision 1ps;

    import tank_pkg::*;

    localparam dir_t   NONE      = 4'b0000;
    localparam coord_t HULL_LO   = coord_t'(`TANK_HULL_MIN);
    localparam coord_t HULL_HI   = coord_t'(`TANK_HULL_MAX);
    localparam coord_t LINE_NEAR = coord_t'(2);  // top and left contact
    localparam coord_t LINE_FAR  = coord_t'(29); // bottom and right contact
    localparam coord_t SPAN_LO   = coord_t'(4);
    localparam coord_t SPAN_HI   = coord_t'(27);

    typedef struct {
        dir_t       move_1;
        dir_t       move_2;
        logic [1:0] shoot; // {player 2, player 1}
        int         ticks;
        coord_t     px;
        coord_t     py;
        logic [2:0] map;   // {solid, hard, destroyable}
        logic [3:0] flags; // {hull 1, hull 2, bullet, collide}
    } row_t;

    logic   clk_i;
    logic   reset_i;
    logic   move_tick_i;
    dir_t   player_1_move_i;
    dir_t   player_2_move_i;
    logic   player_1_shoot_i;
    logic   player_2_shoot_i;
    coord_t hpos_i;
    coord_t vpos_i;
    logic   cannot_walk_through_i;
    logic   hard_block_i;
    logic   destroyable_block_i;
    logic   player_1_pixel_o;
    logic   player_2_pixel_o;
    logic   bullet_pixel_o;
    logic   bullet_collide_o;

    row_t rows [$];
    int   dut_errors;
    int   table_errors;
    int   cycle_limit;

    // reference model state with player 1 at index 0
    coord_t        m_x [2];
    coord_t        m_y [2];
    dir_t          m_head [2];
    logic [3:0]    m_blocked [2];
    bullet_state_t m_state [2];
    coord_t        m_bx [2];
    coord_t        m_by [2];
    dir_t          m_bdir [2];
    logic          m_shoot_q [2];

    tank_arena_top dut0 (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .move_tick_i           (move_tick_i),
        .player_1_move_i       (player_1_move_i),
        .player_2_move_i       (player_2_move_i),
        .player_1_shoot_i      (player_1_shoot_i),
        .player_2_shoot_i      (player_2_shoot_i),
        .hpos_i                (hpos_i),
        .vpos_i                (vpos_i),
        .cannot_walk_through_i (cannot_walk_through_i),
        .hard_block_i          (hard_block_i),
        .destroyable_block_i   (destroyable_block_i),
        .player_1_pixel_o      (player_1_pixel_o),
        .player_2_pixel_o      (player_2_pixel_o),
        .bullet_pixel_o        (bullet_pixel_o),
        .bullet_collide_o      (bullet_collide_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic in_range(input coord_t d, input coord_t lo, input coord_t hi);
        return (d >= lo) && (d <= hi);
    endfunction

    function automatic logic hull_at(input int t);
        coord_t dx;
        coord_t dy;
        dx = hpos_i - m_x[t]; // modulo 1024
        dy = vpos_i - m_y[t];
        return in_range(dx, HULL_LO, HULL_HI) && in_range(dy, HULL_LO, HULL_HI);
    endfunction

    function automatic logic bullet_at(input int t);
        coord_t dx;
        coord_t dy;
        dx = hpos_i - m_bx[t];
        dy = vpos_i - m_by[t];
        return (m_state[t] == FLYING) && (dx <= coord_t'(`BULLET_SIZE)) &&
               (dy <= coord_t'(`BULLET_SIZE));
    endfunction

    function automatic logic [3:0] model_flags();
        logic bullet;
        bullet = bullet_at(0) || bullet_at(1);
        return {hull_at(0), hull_at(1), bullet, bullet && destroyable_block_i};
    endfunction

    task automatic place_muzzle(input int t, output coord_t mx, output coord_t my);
        mx = m_x[t] + coord_t'(`MUZZLE_SIDE);
        my = m_y[t] + coord_t'(`MUZZLE_SIDE);
        case (m_head[t])
            DIR_DOWN:  my = m_y[t] + coord_t'(`MUZZLE_FAR);
            DIR_UP:    my = m_y[t] - coord_t'(`MUZZLE_NEAR);
            DIR_RIGHT: mx = m_x[t] + coord_t'(`MUZZLE_FAR);
            default:   mx = m_x[t] - coord_t'(`MUZZLE_NEAR);
        endcase
    endtask

    task automatic model_reset();
        m_x[0]    = coord_t'(`TANK_P1_X_INIT);
        m_y[0]    = coord_t'(`TANK_P1_Y_INIT);
        m_x[1]    = coord_t'(`TANK_P2_X_INIT);
        m_y[1]    = coord_t'(`TANK_P2_Y_INIT);
        m_head[0] = DIR_DOWN;
        m_head[1] = DIR_UP;
        for (int t = 0; t < 2; t++) begin
            m_blocked[t] = 4'b0000;
            m_state[t]   = IDLE;
            m_shoot_q[t] = 1'b0;
        end
    endtask

    // one clock edge of the model from the inputs the DUT samples there
    task automatic model_edge();
        dir_t       mv [2];
        logic       sh [2];
        coord_t     dx;
        coord_t     dy;
        coord_t     mx;
        coord_t     my;
        logic [3:0] hit;
        logic       onehot;
        logic       bpix;
        mv[0] = player_1_move_i;
        mv[1] = player_2_move_i;
        sh[0] = player_1_shoot_i;
        sh[1] = player_2_shoot_i;
        for (int t = 0; t < 2; t++) begin
            dx     = hpos_i - m_x[t];
            dy     = vpos_i - m_y[t];
            hit[0] = (dy == LINE_FAR) && in_range(dx, SPAN_LO, SPAN_HI);  // bottom
            hit[1] = (dy == LINE_NEAR) && in_range(dx, SPAN_LO, SPAN_HI); // top
            hit[2] = (dx == LINE_FAR) && in_range(dy, SPAN_LO, SPAN_HI);  // right
            hit[3] = (dx == LINE_NEAR) && in_range(dy, SPAN_LO, SPAN_HI); // left
            hit    = hit & {4{cannot_walk_through_i}};
            onehot = $onehot(mv[t]);
            bpix   = bullet_at(t);
            place_muzzle(t, mx, my);
            case (m_state[t])
                IDLE: begin
                    m_bx[t]   = mx;
                    m_by[t]   = my;
                    m_bdir[t] = m_head[t];
                    if (sh[t] && !m_shoot_q[t]) m_state[t] = FLYING;
                end
                FLYING: begin
                    if (move_tick_i) begin
                        case (m_bdir[t])
                            DIR_DOWN:  m_by[t] = m_by[t] + coord_t'(`BULLET_STEP);
                            DIR_UP:    m_by[t] = m_by[t] - coord_t'(`BULLET_STEP);
                            DIR_RIGHT: m_bx[t] = m_bx[t] + coord_t'(`BULLET_STEP);
                            default:   m_bx[t] = m_bx[t] - coord_t'(`BULLET_STEP);
                        endcase
                    end
                    if (bpix && hard_block_i) m_state[t] = SPENT;
                end
                default: m_state[t] = IDLE;
            endcase
            m_shoot_q[t] = sh[t];
            if (move_tick_i && onehot && ((m_blocked[t] & mv[t]) == 4'b0000)) begin
                case (mv[t])
                    DIR_DOWN:  m_y[t] = m_y[t] + coord_t'(`TANK_STEP);
                    DIR_UP:    m_y[t] = m_y[t] - coord_t'(`TANK_STEP);
                    DIR_RIGHT: m_x[t] = m_x[t] + coord_t'(`TANK_STEP);
                    default:   m_x[t] = m_x[t] - coord_t'(`TANK_STEP);
                endcase
                m_head[t] = mv[t];
            end
            m_blocked[t] = (m_blocked[t] & (onehot ? mv[t] : 4'b1111)) | hit; // set wins
        end
    endtask

    //////////////////////////////////////////////////
    // table and row sequencing
    //////////////////////////////////////////////////

    task automatic add_row(input dir_t m1, input dir_t m2, input logic [1:0] shoot,
                           input int ticks, input int x, input int y,
                           input logic [2:0] map, input logic [3:0] flags);
        row_t r;
        r.move_1 = m1;
        r.move_2 = m2;
        r.shoot  = shoot;
        r.ticks  = ticks;
        r.px     = coord_t'(x);
        r.py     = coord_t'(y);
        r.map    = map;
        r.flags  = flags;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(NONE, NONE, 2'b00, 0, 227, 35, 3'b000, 4'b1000);   // reset pose
        add_row(NONE, NONE, 2'b00, 0, 252, 60, 3'b000, 4'b1000);
        add_row(NONE, NONE, 2'b00, 0, 226, 35, 3'b000, 4'b0000);
        add_row(NONE, NONE, 2'b00, 0, 253, 60, 3'b000, 4'b0000);
        add_row(NONE, NONE, 2'b00, 0, 227, 419, 3'b000, 4'b0100);
        add_row(NONE, NONE, 2'b00, 0, 252, 445, 3'b000, 4'b0000);
        add_row(NONE, NONE, 2'b00, 0, 252, 444, 3'b000, 4'b0100);
        add_row(NONE, NONE, 2'b00, 0, 226, 418, 3'b000, 4'b0000);
        add_row(NONE, NONE, 2'b00, 0, 238, 64, 3'b001, 4'b0000);   // idle muzzle
        add_row(DIR_RIGHT, DIR_UP, 2'b00, 5, 232, 35, 3'b000, 4'b1000);
        add_row(NONE, NONE, 2'b00, 0, 231, 35, 3'b000, 4'b0000);
        add_row(NONE, NONE, 2'b00, 0, 227, 414, 3'b000, 4'b0100);
        add_row(NONE, NONE, 2'b00, 0, 227, 413, 3'b000, 4'b0000);
        add_row(DIR_LEFT, DIR_DOWN, 2'b00, 0, 257, 35, 3'b000, 4'b1000); // no tick
        add_row(NONE, NONE, 2'b00, 0, 227, 414, 3'b000, 4'b0100);
        add_row(NONE, NONE, 2'b00, 0, 258, 42, 3'b100, 4'b0000);   // right wall
        add_row(DIR_RIGHT, NONE, 2'b00, 3, 232, 35, 3'b000, 4'b1000);
        add_row(DIR_LEFT, NONE, 2'b00, 2, 230, 35, 3'b000, 4'b1000);
        add_row(NONE, NONE, 2'b00, 0, 229, 35, 3'b000, 4'b0000);
        add_row(DIR_RIGHT, NONE, 2'b00, 4, 234, 35, 3'b000, 4'b1000);
        add_row(NONE, NONE, 2'b00, 0, 233, 35, 3'b000, 4'b0000);
        add_row(NONE, NONE, 2'b01, 0, 263, 46, 3'b000, 4'b0010);   // fire right
        add_row(NONE, NONE, 2'b01, 3, 275, 46, 3'b000, 4'b0010);
        add_row(NONE, NONE, 2'b01, 0, 279, 50, 3'b000, 4'b0010);
        add_row(NONE, NONE, 2'b00, 0, 274, 46, 3'b000, 4'b0000);
        add_row(NONE, NONE, 2'b01, 2, 283, 46, 3'b000, 4'b0010);   // edge in flight
        add_row(DIR_DOWN, NONE, 2'b01, 2, 291, 46, 3'b000, 4'b0010);
        add_row(NONE, NONE, 2'b01, 0, 291, 46, 3'b001, 4'b0011);   // brick
        add_row(NONE, NONE, 2'b01, 0, 291, 46, 3'b011, 4'b0011);   // hard block
        add_row(NONE, NONE, 2'b00, 0, 291, 46, 3'b001, 4'b0000);
        add_row(NONE, NONE, 2'b01, 0, 245, 66, 3'b001, 4'b0011);   // fire down
        add_row(NONE, NONE, 2'b01, 2, 245, 74, 3'b000, 4'b0010);
        add_row(NONE, NONE, 2'b11, 0, 238, 407, 3'b000, 4'b0010);  // player 2 fires
        add_row(NONE, NONE, 2'b11, 3, 240, 397, 3'b000, 4'b0010);
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        assert (got === want) else begin
            dut_errors++;
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_row(input int idx);
        logic [3:0] want;
        want = model_flags();
        assert (want == rows[idx].flags) else begin
            table_errors++;
            $display("row %0d expects flags %b but the reference model gives %b",
                     idx, rows[idx].flags, want);
        end
        check_flag("player_1_pixel_o", player_1_pixel_o, rows[idx].flags[3]);
        check_flag("player_2_pixel_o", player_2_pixel_o, rows[idx].flags[2]);
        check_flag("bullet_pixel_o", bullet_pixel_o, rows[idx].flags[1]);
        check_flag("bullet_collide_o", bullet_collide_o, rows[idx].flags[0]);
    endtask

    // drive phase with the row's commands and then one probe cycle
    task automatic apply_row(input int idx);
        int n;
        n = (rows[idx].ticks > 0) ? rows[idx].ticks : 1;
        repeat (n) begin
            @(posedge clk_i);
            model_edge();
            player_1_move_i       <= rows[idx].move_1;
            player_2_move_i       <= rows[idx].move_2;
            player_1_shoot_i      <= rows[idx].shoot[0];
            player_2_shoot_i      <= rows[idx].shoot[1];
            move_tick_i           <= (rows[idx].ticks > 0);
            hpos_i                <= rows[idx].px;
            vpos_i                <= rows[idx].py;
            cannot_walk_through_i <= 1'b0;
            hard_block_i          <= 1'b0;
            destroyable_block_i   <= 1'b0;
        end
        @(posedge clk_i);
        model_edge();
        player_1_move_i       <= NONE;
        player_2_move_i       <= NONE;
        move_tick_i           <= 1'b0;
        cannot_walk_through_i <= rows[idx].map[2];
        hard_block_i          <= rows[idx].map[1];
        destroyable_block_i   <= rows[idx].map[0];
        @(negedge clk_i); // combinational outputs settled
        check_row(idx);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        reset_i               <= 1'b1;
        move_tick_i           <= 1'b0;
        player_1_move_i       <= NONE;
        player_2_move_i       <= NONE;
        player_1_shoot_i      <= 1'b0;
        player_2_shoot_i      <= 1'b0;
        hpos_i                <= coord_t'(0);
        vpos_i                <= coord_t'(0);
        cannot_walk_through_i <= 1'b0;
        hard_block_i          <= 1'b0;
        destroyable_block_i   <= 1'b0;
        dut_errors   = 0;
        table_errors = 0;
        build_table();
        cycle_limit = 10 + 50; // reset plus margin
        foreach (rows[i]) cycle_limit += ((rows[i].ticks > 0) ? rows[i].ticks : 1) + 1;
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        model_reset();
        foreach (rows[i]) apply_row(i);
        $display("checks done: %0d output mismatches, %0d table errors",
                 dut_errors, table_errors);
        if (dut_errors == 0 && table_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        int count;
        count = 0;
        wait (cycle_limit != 0);
        while (count < cycle_limit) begin
            @(posedge clk_i);
            count++;
        end
        $display("timeout: the table did not finish within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

endmodule
